//--- common/ib_pkg.sv
// instruction buffer package
// widths, shift and debug command types, and encoding constants for injected instructions

package ib_pkg;

   localparam int IB_DEPTH = 4;   // buffer entries
   localparam int INSTR_W  = 32;

   typedef logic [INSTR_W-1:0] instr_t;

   // how many places the entries move down this cycle
   typedef enum logic [1:0] {
      SHIFT_NONE = 2'd0,
      SHIFT_ONE  = 2'd1,
      SHIFT_TWO  = 2'd2
   } shift_e;

   // debug command type as it arrives from the debug module
   typedef enum logic [1:0] {
      DBG_GPR = 2'd0,
      DBG_CSR = 2'd1,
      DBG_MEM = 2'd2   // memory access, handled elsewhere
   } dbg_cmd_e;

   // major opcodes
   localparam logic [6:0] OP_REG    = 7'b0110011;
   localparam logic [6:0] OP_SYSTEM = 7'b1110011;

   // function codes
   localparam logic [2:0] F3_OR    = 3'b110;
   localparam logic [2:0] F3_CSRRW = 3'b001;
   localparam logic [2:0] F3_CSRRS = 3'b010;

   // write here fences the core in debug mode
   localparam logic [11:0] CSR_DBG_FENCE = 12'h7c4;

endpackage

//--- instbuf/ib_ctl.sv
// instruction buffer control
// valid vector, registered flush, accept rule, shift amount and write positions

`timescale 1ns/1ns

module ib_ctl (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          exu_flush,
   input  logic                          ifu_i0_valid,
   input  logic                          ifu_i1_valid,
   input  logic                          dec_i0_decode,
   input  logic                          dec_i1_decode,
   input  logic                          dbg_inject,      // debug word goes to entry 0
   output logic [ib_pkg::IB_DEPTH-1:0]   ib_valid,
   output logic [ib_pkg::IB_DEPTH-1:0]   write_i0_sel,
   output logic [ib_pkg::IB_DEPTH-1:1]   write_i1_sel,
   output ib_pkg::shift_e                shift_sel
);

   localparam int D = ib_pkg::IB_DEPTH;

   logic         flush_q;
   logic [D-1:0] shift_val;   // valids after this cycle's consumption
   logic [D-1:0] valid_nxt;
   logic         i0_acc;
   logic         i1_acc;

   always_ff @(posedge clk) begin
      if (rst) begin
         flush_q  <= 1'b0;
         ib_valid <= '0;
      end else begin
         flush_q  <= exu_flush;
         ib_valid <= valid_nxt;
      end
   end

   // room check on current valids, debug command blocks fetch
   assign i0_acc = ifu_i0_valid & ~ib_valid[3] & ~flush_q & ~dbg_inject;
   assign i1_acc = ifu_i1_valid & ~ib_valid[2] & ~flush_q & ~dbg_inject;

   always_comb begin
      if (!dec_i0_decode)
         shift_sel = ib_pkg::SHIFT_NONE;
      else if (dec_i1_decode)
         shift_sel = ib_pkg::SHIFT_TWO;
      else
         shift_sel = ib_pkg::SHIFT_ONE;
   end

   always_comb begin
      case (shift_sel)
         ib_pkg::SHIFT_ONE: shift_val = {1'b0, ib_valid[D-1:1]};
         ib_pkg::SHIFT_TWO: shift_val = {2'b00, ib_valid[D-1:2]};
         default:           shift_val = ib_valid;
      endcase
   end

   // i0 lands in the first free entry after the shift, i1 right behind it
   always_comb begin
      write_i0_sel[0] = ~shift_val[0] & (i0_acc | dbg_inject);
      for (int k = 1; k < D; k++) begin
         write_i0_sel[k] = shift_val[k-1] & ~shift_val[k] & i0_acc;
      end
      write_i1_sel[1] = ~shift_val[0] & i1_acc;
      for (int k = 2; k < D; k++) begin
         write_i1_sel[k] = shift_val[k-2] & ~shift_val[k-1] & i1_acc;
      end
   end

   assign valid_nxt = (shift_val | write_i0_sel | {write_i1_sel, 1'b0}) & ~{D{flush_q}};

   a_i1_needs_i0: assert property (@(posedge clk) disable iff (rst)
      ifu_i1_valid |-> ifu_i0_valid);

   a_dec_i1_needs_i0: assert property (@(posedge clk) disable iff (rst)
      dec_i1_decode |-> dec_i0_decode);

   // decode only consumes entries that hold something
   a_dec_valid_entry: assert property (@(posedge clk) disable iff (rst)
      (dec_i0_decode |-> ib_valid[0]) and (dec_i1_decode |-> ib_valid[1]));

   a_valid_contig: assert property (@(posedge clk) disable iff (rst)
      ib_valid inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111});

endmodule

//--- instbuf/ib_slots.sv
// instruction buffer entry storage
// four entries of instruction, pc and pc4, loaded from fetch or shifted down

`timescale 1ns/1ns

module ib_slots #(
   parameter int PC_W = 31
) (
   input  logic                          clk,
   input  logic [ib_pkg::IB_DEPTH-1:0]   write_i0_sel,
   input  logic [ib_pkg::IB_DEPTH-1:1]   write_i1_sel,
   input  ib_pkg::shift_e                shift_sel,
   input  ib_pkg::instr_t                slot_i0_instr,
   input  ib_pkg::instr_t                ifu_i1_instr,
   input  logic [PC_W-1:0]               ifu_i0_pc,
   input  logic [PC_W-1:0]               ifu_i1_pc,
   input  logic                          ifu_i0_pc4,
   input  logic                          ifu_i1_pc4,
   output ib_pkg::instr_t                dec_i0_instr,
   output ib_pkg::instr_t                dec_i1_instr,
   output logic [PC_W-1:0]               dec_i0_pc,
   output logic [PC_W-1:0]               dec_i1_pc,
   output logic                          dec_i0_pc4,
   output logic                          dec_i1_pc4
);

   localparam int D     = ib_pkg::IB_DEPTH;
   localparam int ENT_W = ib_pkg::INSTR_W + PC_W + 1;   // {instr, pc, pc4}

   logic [ENT_W-1:0] ent [D];
   logic [ENT_W-1:0] i0_data;
   logic [ENT_W-1:0] i1_data;
   logic [D-1:0]     i1_sel;   // entry 0 never takes i1

   assign i0_data = {slot_i0_instr, ifu_i0_pc, ifu_i0_pc4};
   assign i1_data = {ifu_i1_instr, ifu_i1_pc, ifu_i1_pc4};
   assign i1_sel  = {write_i1_sel, 1'b0};

   for (genvar k = 0; k < D; k++) begin : g_ent
      logic [ENT_W-1:0] above1;
      logic [ENT_W-1:0] above2;

      // top entries have nothing above; they hold and their valid drops anyway
      assign above1 = ent[(k + 1 < D) ? k + 1 : k];
      assign above2 = ent[(k + 2 < D) ? k + 2 : k];

      always_ff @(posedge clk) begin
         if (write_i0_sel[k])
            ent[k] <= i0_data;
         else if (i1_sel[k])
            ent[k] <= i1_data;
         else if (shift_sel == ib_pkg::SHIFT_ONE)
            ent[k] <= above1;
         else if (shift_sel == ib_pkg::SHIFT_TWO)
            ent[k] <= above2;
      end
   end

   // entries 0 and 1 face decode
   assign {dec_i0_instr, dec_i0_pc, dec_i0_pc4} = ent[0];
   assign {dec_i1_instr, dec_i1_pc, dec_i1_pc4} = ent[1];

endmodule

//--- source/dbg_inst_gen.sv
// debug instruction generator
// turns a GPR or CSR debug command into an instruction for entry 0, registers rs1 and fence flags

`timescale 1ns/1ns

module dbg_inst_gen (
   input  logic              clk,
   input  logic              rst,
   input  logic              dbg_cmd_valid,
   input  logic              dbg_cmd_write,
   input  ib_pkg::dbg_cmd_e  dbg_cmd_type,
   input  logic [11:0]       dbg_cmd_addr,
   input  ib_pkg::instr_t    ifu_i0_instr,
   output logic              dbg_inject,
   output ib_pkg::instr_t    slot_i0_instr,
   output logic              dbg_wdata_rs1,   // write data travels on rs1
   output logic              dbg_fence
);

   logic           is_gpr;
   logic           is_csr;
   logic [4:0]     dreg;
   ib_pkg::instr_t dbg_word;

   assign dbg_inject = dbg_cmd_valid & (dbg_cmd_type != ib_pkg::DBG_MEM);   // memory goes elsewhere
   assign is_gpr     = dbg_cmd_type == ib_pkg::DBG_GPR;
   assign is_csr     = dbg_cmd_type == ib_pkg::DBG_CSR;
   assign dreg       = dbg_cmd_addr[4:0];

   always_comb begin
      dbg_word = '0;
      if (is_gpr && dbg_cmd_write)
         dbg_word = {12'b0, 5'b0, ib_pkg::F3_OR, dreg, ib_pkg::OP_REG};        // or reg, x0, x0
      else if (is_gpr)
         dbg_word = {12'b0, dreg, ib_pkg::F3_OR, 5'b0, ib_pkg::OP_REG};        // or x0, reg, x0
      else if (is_csr && dbg_cmd_write)
         dbg_word = {dbg_cmd_addr, 5'b0, ib_pkg::F3_CSRRW, 5'b0, ib_pkg::OP_SYSTEM};
      else if (is_csr)
         dbg_word = {dbg_cmd_addr, 5'b0, ib_pkg::F3_CSRRS, 5'b0, ib_pkg::OP_SYSTEM};
   end

   assign slot_i0_instr = dbg_inject ? dbg_word : ifu_i0_instr;

   // core is halted, so the write data is wanted the very next cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         dbg_wdata_rs1 <= 1'b0;
         dbg_fence     <= 1'b0;
      end else begin
         dbg_wdata_rs1 <= dbg_inject & dbg_cmd_write & (is_gpr | is_csr);
         dbg_fence     <= dbg_inject & dbg_cmd_write & is_csr &
                          (dbg_cmd_addr == ib_pkg::CSR_DBG_FENCE);
      end
   end

endmodule

//--- source/ib_top.sv
// decode instruction buffer, top level
// four entries, two-wide fetch write, debug instruction injection into entry 0

`timescale 1ns/1ns

module ib_top #(
   parameter int PC_W = 31   // pc bits [31:1]
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          exu_flush,

   input  logic                          ifu_i0_valid,
   input  logic                          ifu_i1_valid,
   input  ib_pkg::instr_t                ifu_i0_instr,
   input  ib_pkg::instr_t                ifu_i1_instr,
   input  logic [PC_W-1:0]               ifu_i0_pc,
   input  logic [PC_W-1:0]               ifu_i1_pc,
   input  logic                          ifu_i0_pc4,
   input  logic                          ifu_i1_pc4,

   input  logic                          dec_i0_decode,
   input  logic                          dec_i1_decode,

   input  logic                          dbg_cmd_valid,
   input  logic                          dbg_cmd_write,
   input  ib_pkg::dbg_cmd_e              dbg_cmd_type,
   input  logic [11:0]                   dbg_cmd_addr,

   output logic [ib_pkg::IB_DEPTH-1:0]   ib_valid,
   output ib_pkg::instr_t                dec_i0_instr,
   output ib_pkg::instr_t                dec_i1_instr,
   output logic [PC_W-1:0]               dec_i0_pc,
   output logic [PC_W-1:0]               dec_i1_pc,
   output logic                          dec_i0_pc4,
   output logic                          dec_i1_pc4,
   output logic                          dbg_wdata_rs1,
   output logic                          dbg_fence
);

   logic [ib_pkg::IB_DEPTH-1:0] write_i0_sel;
   logic [ib_pkg::IB_DEPTH-1:1] write_i1_sel;
   ib_pkg::shift_e              shift_sel;
   logic                        dbg_inject;
   ib_pkg::instr_t              slot_i0_instr;   // debug word or fetch i0

   ib_ctl u_ctl (
      .clk, .rst, .exu_flush,
      .ifu_i0_valid, .ifu_i1_valid,
      .dec_i0_decode, .dec_i1_decode,
      .dbg_inject,
      .ib_valid, .write_i0_sel, .write_i1_sel, .shift_sel
   );

   ib_slots #(.PC_W(PC_W)) u_slots (
      .clk,
      .write_i0_sel, .write_i1_sel, .shift_sel,
      .slot_i0_instr, .ifu_i1_instr,
      .ifu_i0_pc, .ifu_i1_pc, .ifu_i0_pc4, .ifu_i1_pc4,
      .dec_i0_instr, .dec_i1_instr,
      .dec_i0_pc, .dec_i1_pc, .dec_i0_pc4, .dec_i1_pc4
   );

   dbg_inst_gen u_dbg (
      .clk, .rst,
      .dbg_cmd_valid, .dbg_cmd_write, .dbg_cmd_type, .dbg_cmd_addr,
      .ifu_i0_instr,
      .dbg_inject, .slot_i0_instr, .dbg_wdata_rs1, .dbg_fence
   );

endmodule

//--- sim/tb_clock.sv
// testbench clock and reset generator
// free-running clock, reset held high for the first few rising edges

`timescale 1ns/1ns

module tb_clock #(
   parameter int PERIOD     = 100,
   parameter int RST_CYCLES = 2
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial begin
      rst = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      rst <= 1'b0;   // released on a rising edge
   end

endmodule

//--- sim/tb_ib.sv
// instruction buffer testbench
// random fetch, decode, flush and debug traffic checked against a queue model

`timescale 1ns/1ns

module tb_ib;

   localparam int PC_W       = 31;
   localparam int D          = ib_pkg::IB_DEPTH;
   localparam int N_CYCLES   = 2000;
   localparam int CLK_PERIOD = 100;

   logic                clk;
   logic                rst;
   logic                exu_flush;
   logic                ifu_i0_valid;
   logic                ifu_i1_valid;
   ib_pkg::instr_t      ifu_i0_instr;
   ib_pkg::instr_t      ifu_i1_instr;
   logic [PC_W-1:0]     ifu_i0_pc;
   logic [PC_W-1:0]     ifu_i1_pc;
   logic                ifu_i0_pc4;
   logic                ifu_i1_pc4;
   logic                dec_i0_decode;
   logic                dec_i1_decode;
   logic                dbg_cmd_valid;
   logic                dbg_cmd_write;
   ib_pkg::dbg_cmd_e    dbg_cmd_type;
   logic [11:0]         dbg_cmd_addr;
   logic [D-1:0]        ib_valid;
   ib_pkg::instr_t      dec_i0_instr;
   ib_pkg::instr_t      dec_i1_instr;
   logic [PC_W-1:0]     dec_i0_pc;
   logic [PC_W-1:0]     dec_i1_pc;
   logic                dec_i0_pc4;
   logic                dec_i1_pc4;
   logic                dbg_wdata_rs1;
   logic                dbg_fence;

   // reference model with entry 0 at the front of the queues
   ib_pkg::instr_t      q_instr[$];
   logic [PC_W-1:0]     q_pc[$];
   logic                q_pc4[$];
   logic                m_flush_q;
   logic                exp_rs1;
   logic                exp_fence;

   int seed = 69;
   int cyc;
   int n_land;    // debug words that reached entry 0
   int n_fence;
   int n_drop;    // i0 offers refused by a full buffer

   tb_clock #(.PERIOD(CLK_PERIOD), .RST_CYCLES(2)) u_clock (.clk, .rst);

   ib_top #(.PC_W(PC_W)) u_dut (.*);

   task automatic report_failure(input string what);
      $display("Testbench failed");
      $fatal(1, "%s", what);
   endtask

   task automatic check_valid(input string name, input logic [D-1:0] exp,
                              input logic [D-1:0] act);
      if (act !== exp) begin
         $display("ERR %s cycle %0d expected %b actual %b", name, cyc, exp, act);
         report_failure("valid vector mismatch");
      end
   endtask

   task automatic check_instr(input string name, input ib_pkg::instr_t exp,
                              input ib_pkg::instr_t act);
      if (act !== exp) begin
         $display("ERR %s cycle %0d expected %h actual %h", name, cyc, exp, act);
         report_failure("instruction word mismatch");
      end
   endtask

   task automatic check_pc(input string name, input logic [PC_W-1:0] exp_pc,
                           input logic exp_pc4, input logic [PC_W-1:0] act_pc,
                           input logic act_pc4);
      if (act_pc !== exp_pc || act_pc4 !== exp_pc4) begin
         $display("ERR %s cycle %0d expected pc %h pc4 %b actual pc %h pc4 %b",
                  name, cyc, exp_pc, exp_pc4, act_pc, act_pc4);
         report_failure("pc mismatch");
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR %s cycle %0d expected %b actual %b", name, cyc, exp, act);
         report_failure("debug flag mismatch");
      end
   endtask

   // debug word built from the RISC-V field positions
   function automatic ib_pkg::instr_t encode_dbg(input logic wr, input ib_pkg::dbg_cmd_e t,
                                                 input logic [11:0] a);
      logic [31:0] w;
      if (t == ib_pkg::DBG_GPR && wr)
         w = (32'(a[4:0]) << 7) | (32'(ib_pkg::F3_OR) << 12) | 32'(ib_pkg::OP_REG);
      else if (t == ib_pkg::DBG_GPR)
         w = (32'(a[4:0]) << 15) | (32'(ib_pkg::F3_OR) << 12) | 32'(ib_pkg::OP_REG);
      else if (wr)
         w = (32'(a) << 20) | (32'(ib_pkg::F3_CSRRW) << 12) | 32'(ib_pkg::OP_SYSTEM);
      else
         w = (32'(a) << 20) | (32'(ib_pkg::F3_CSRRS) << 12) | 32'(ib_pkg::OP_SYSTEM);
      return w;
   endfunction

   task automatic push_entry(input ib_pkg::instr_t instr, input logic [PC_W-1:0] pc,
                             input logic pc4);
      q_instr.push_back(instr);
      q_pc.push_back(pc);
      q_pc4.push_back(pc4);
   endtask

   // one rising edge of the model, using the inputs the DUT samples there
   task automatic model_edge();
      int   n_before;
      int   n_shift;
      logic dbg_hit;
      logic i0_ok;
      logic i1_ok;
      n_before = q_instr.size();
      n_shift  = dec_i0_decode ? (dec_i1_decode ? 2 : 1) : 0;
      dbg_hit  = dbg_cmd_valid && (dbg_cmd_type != ib_pkg::DBG_MEM);
      i0_ok    = ifu_i0_valid && (n_before < D) && !m_flush_q && !dbg_hit;
      i1_ok    = ifu_i1_valid && (n_before < D - 1) && !m_flush_q && !dbg_hit;
      repeat (n_shift) begin
         q_instr.delete(0);
         q_pc.delete(0);
         q_pc4.delete(0);
      end
      if (dbg_hit && q_instr.size() == 0) begin   // lands only in a free entry 0
         push_entry(encode_dbg(dbg_cmd_write, dbg_cmd_type, dbg_cmd_addr),
                    ifu_i0_pc, ifu_i0_pc4);
         if (!m_flush_q)
            n_land++;
      end
      if (i0_ok)
         push_entry(ifu_i0_instr, ifu_i0_pc, ifu_i0_pc4);
      if (i1_ok)
         push_entry(ifu_i1_instr, ifu_i1_pc, ifu_i1_pc4);
      if (ifu_i0_valid && n_before == D)
         n_drop++;
      if (m_flush_q) begin
         q_instr.delete();
         q_pc.delete();
         q_pc4.delete();
      end
      exp_rs1   = dbg_hit && dbg_cmd_write;
      exp_fence = exp_rs1 && dbg_cmd_type == ib_pkg::DBG_CSR &&
                  dbg_cmd_addr == ib_pkg::CSR_DBG_FENCE;
      if (exp_fence)
         n_fence++;
      m_flush_q = exu_flush;
   endtask

   task automatic drive_inputs();
      logic [31:0] rnd;
      logic        dbg_cyc;
      int          want;
      dbg_cyc = ($random(seed) & 7) == 0;
      rnd     = $random(seed);
      exu_flush <= ($random(seed) & 31) == 0;
      // alternate light and heavy decode phases so the buffer fills and drains
      if (dbg_cyc)
         want = 2;
      else if ((cyc / 64) % 2 == 1)
         want = (rnd[1:0] == 2'd0) ? 1 : 2;
      else
         want = (rnd[1:0] < 2'd2) ? 0 : int'(rnd[1:0]) - 1;
      if (want > q_instr.size())
         want = q_instr.size();
      dec_i0_decode <= want >= 1;
      dec_i1_decode <= want >= 2;
      ifu_i0_valid  <= !dbg_cyc && rnd[3:2] != 2'd0;
      ifu_i1_valid  <= !dbg_cyc && rnd[3];   // i1 only together with i0
      ifu_i0_instr  <= $random(seed);
      ifu_i1_instr  <= $random(seed);
      rnd = $random(seed);
      ifu_i0_pc  <= rnd[PC_W-1:0];
      ifu_i0_pc4 <= rnd[31];
      rnd = $random(seed);
      ifu_i1_pc  <= rnd[PC_W-1:0];
      ifu_i1_pc4 <= rnd[31];
      rnd = $random(seed);
      dbg_cmd_valid <= dbg_cyc;
      dbg_cmd_write <= rnd[0];
      case (rnd[2:1])
         2'd0:    dbg_cmd_type <= ib_pkg::DBG_GPR;
         2'd2:    dbg_cmd_type <= ib_pkg::DBG_MEM;
         default: dbg_cmd_type <= ib_pkg::DBG_CSR;
      endcase
      dbg_cmd_addr <= (rnd[2:1] != 2'd0 && rnd[3]) ? ib_pkg::CSR_DBG_FENCE : rnd[15:4];
   endtask

   task automatic compare_outputs();
      logic [D-1:0] exp_valid;
      for (int k = 0; k < D; k++)
         exp_valid[k] = k < q_instr.size();
      check_valid("ib_valid", exp_valid, ib_valid);
      if (q_instr.size() >= 1) begin
         check_instr("entry0 instr", q_instr[0], dec_i0_instr);
         check_pc("entry0 pc", q_pc[0], q_pc4[0], dec_i0_pc, dec_i0_pc4);
      end
      if (q_instr.size() >= 2) begin
         check_instr("entry1 instr", q_instr[1], dec_i1_instr);
         check_pc("entry1 pc", q_pc[1], q_pc4[1], dec_i1_pc, dec_i1_pc4);
      end
      check_flag("dbg_wdata_rs1", exp_rs1, dbg_wdata_rs1);
      check_flag("dbg_fence", exp_fence, dbg_fence);
   endtask

   initial begin
      #(2 * N_CYCLES * CLK_PERIOD);
      $display("timeout: the random run did not complete in time");
      report_failure("watchdog expired");
   end

   initial begin
      exu_flush     = 1'b0;
      ifu_i0_valid  = 1'b0;
      ifu_i1_valid  = 1'b0;
      ifu_i0_instr  = '0;
      ifu_i1_instr  = '0;
      ifu_i0_pc     = '0;
      ifu_i1_pc     = '0;
      ifu_i0_pc4    = 1'b0;
      ifu_i1_pc4    = 1'b0;
      dec_i0_decode = 1'b0;
      dec_i1_decode = 1'b0;
      dbg_cmd_valid = 1'b0;
      dbg_cmd_write = 1'b0;
      dbg_cmd_type  = ib_pkg::DBG_GPR;
      dbg_cmd_addr  = '0;
      m_flush_q     = 1'b0;
      exp_rs1       = 1'b0;
      exp_fence     = 1'b0;
      cyc           = 0;
      n_land        = 0;
      n_fence       = 0;
      n_drop        = 0;
      @(negedge rst);
      @(negedge clk);
      compare_outputs();   // all clear out of reset
      for (cyc = 0; cyc < N_CYCLES; cyc++) begin
         @(posedge clk);
         model_edge();
         drive_inputs();
         @(negedge clk);
         compare_outputs();
      end
      if (n_land == 0 || n_fence == 0 || n_drop == 0) begin
         $display("coverage hole: no debug landing, no fence or no refused offer seen");
         report_failure("stimulus missed a behavior");
      end else begin
         $display("Testbench passed");
         $finish;
      end
   end

endmodule

//--- compile.f
common/ib_pkg.sv
instbuf/ib_ctl.sv
instbuf/ib_slots.sv
source/dbg_inst_gen.sv
source/ib_top.sv
sim/tb_clock.sv
sim/tb_ib.sv
